//--- logic/axi_sram_slave.sv
`timescale 1ns/100ps
`include "mem_subsystem_consts.svh"

module axi_sram_slave (
	input  logic                         clk,
	input  logic                         rst_n,
	input  mem_subsystem_pkg::axi_req_t  axi_req_i,
	output mem_subsystem_pkg::axi_resp_t axi_resp_o
);

	localparam int STRB_W    = `MS_DATA_W / 8;
	localparam int LANE_BITS = $clog2(STRB_W);
	localparam int WRAP_BITS = $clog2(`MS_BURST_BEATS);
	localparam int IDX_W     = $clog2(`MS_SRAM_WORDS);
	localparam logic [1:0] BURST_WRAP = 2'b10;

	logic [`MS_DATA_W-1:0] mem [`MS_SRAM_WORDS];

	logic                  rd_active_q, wr_active_q, b_pend_q;
	logic [`MS_ADDR_W-1:0] addr_q, addr_next;
	logic [7:0]            len_q, cnt_q;
	logic [1:0]            burst_q;
	logic                  idle, aw_hs, ar_hs, w_beat, r_beat, last_beat;
	logic [IDX_W-1:0]      word_idx;
	mem_subsystem_pkg::axi_ax_t ax_sel;

	assign idle      = !(rd_active_q || wr_active_q || b_pend_q);
	assign aw_hs     = axi_req_i.aw_valid && idle;
	assign ar_hs     = axi_req_i.ar_valid && idle;
	assign w_beat    = axi_req_i.w_valid && wr_active_q;
	assign r_beat    = rd_active_q && axi_req_i.r_ready;
	assign last_beat = (cnt_q == len_q);
	assign word_idx  = addr_q[LANE_BITS +: IDX_W];
	assign ax_sel    = aw_hs ? axi_req_i.aw : axi_req_i.ar;   // write wins a tie

	// next beat address, wraps inside the aligned block
	always_comb begin
		addr_next = addr_q + `MS_ADDR_W'(STRB_W);
		if (burst_q == BURST_WRAP) begin
			addr_next = addr_q;
			addr_next[LANE_BITS +: WRAP_BITS] = addr_q[LANE_BITS +: WRAP_BITS] + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_active_q <= 1'b0;
			wr_active_q <= 1'b0;
			b_pend_q    <= 1'b0;
		end else begin
			if (aw_hs) begin
				wr_active_q <= 1'b1;
			end else if (ar_hs) begin
				rd_active_q <= 1'b1;
			end
			if (w_beat && last_beat) begin
				wr_active_q <= 1'b0;
				b_pend_q    <= 1'b1;
			end
			if (r_beat && last_beat) rd_active_q <= 1'b0;
			if (b_pend_q && axi_req_i.b_ready) b_pend_q <= 1'b0;
		end
	end

	// burst bookkeeping
	always_ff @(posedge clk) begin
		if (aw_hs || ar_hs) begin
			addr_q  <= {ax_sel.addr[`MS_ADDR_W-1:LANE_BITS], {LANE_BITS{1'b0}}};
			len_q   <= ax_sel.len;
			burst_q <= ax_sel.burst_type;
			cnt_q   <= '0;
		end else if (w_beat || r_beat) begin
			addr_q <= addr_next;
			cnt_q  <= cnt_q + 1'b1;
		end
	end

	// byte lanes follow w_strb
	always_ff @(posedge clk) begin
		if (w_beat) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (axi_req_i.w_strb[b]) begin
					mem[word_idx][8*b +: 8] <= axi_req_i.w_data[8*b +: 8];
				end
			end
		end
	end

	assign axi_resp_o.aw_ready = idle;
	assign axi_resp_o.ar_ready = idle;
	assign axi_resp_o.w_ready  = wr_active_q;
	assign axi_resp_o.r_data   = mem[word_idx];
	assign axi_resp_o.r_last   = rd_active_q && last_beat;
	assign axi_resp_o.r_valid  = rd_active_q;
	assign axi_resp_o.b_valid  = b_pend_q;

	// master must end on the beat counted as last
	a_w_last_align: assert property (
		@(posedge clk) disable iff (!rst_n)
		w_beat |-> (axi_req_i.w_last == last_beat)
	);

	// no stray beat outside an open burst
	a_w_in_burst: assert property (
		@(posedge clk) disable iff (!rst_n)
		axi_req_i.w_valid |-> wr_active_q
	);

endmodule

//--- logic/cache_axi_converter.sv
`timescale 1ns/100ps
`include "mem_subsystem_consts.svh"

module cache_axi_converter #(
	parameter int CACHE_PORT_NUM = 2
) (
	input  logic                                                clk,
	input  logic                                                rst_n,
	input  mem_subsystem_pkg::cache_bus_req_t  [CACHE_PORT_NUM-1:0] req_i,
	output mem_subsystem_pkg::cache_bus_resp_t [CACHE_PORT_NUM-1:0] resp_o,
	output mem_subsystem_pkg::axi_req_t                         axi_req_o,
	input  mem_subsystem_pkg::axi_resp_t                        axi_resp_i
);

	localparam logic [3:0] ST_IDLE = 4'b0001;
	localparam logic [3:0] ST_ADDR = 4'b0010;
	localparam logic [3:0] ST_DATA = 4'b0100;
	localparam logic [3:0] ST_RESP = 4'b1000;

	// fields kept for the whole transaction
	typedef struct packed {
		logic                  write;
		logic                  burst;
		logic                  cached;
		logic [`MS_ADDR_W-1:0] addr;
	} txn_info_t;

	logic [3:0]                state_q, state_d;
	logic                      in_idle, in_addr, in_data, in_resp;
	logic                      take;
	logic [CACHE_PORT_NUM-1:0] req_valid;
	logic [CACHE_PORT_NUM-1:0] sel_comb;
	logic [CACHE_PORT_NUM-1:0] sel_q;
	logic [CACHE_PORT_NUM-1:0] grant;
	txn_info_t                 info_d, info_q;
	mem_subsystem_pkg::cache_bus_req_t sel_port;
	mem_subsystem_pkg::axi_ax_t        ax;

	logic                      can_load, load_beat, wr_ack;
	logic                      wr_done_q;
	logic                      beat_valid_q;
	logic [`MS_DATA_W-1:0]     beat_data_q;
	logic [`MS_DATA_W/8-1:0]   beat_strb_q;
	logic                      beat_last_q;
	logic                      rd_beat, rd_last;

	assign in_idle = state_q[0];
	assign in_addr = state_q[1];
	assign in_data = state_q[2];
	assign in_resp = state_q[3];
	assign take    = in_idle;

	rr_arbiter #(
		.REQ_NUM (CACHE_PORT_NUM)
	) u_rr_arbiter (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_i      (req_valid),
		.take_sel_i (take),
		.sel_o      (sel_comb)
	);

	// request fields of the arbiter's pick
	always_comb begin
		info_d = '0;
		for (int i = 0; i < CACHE_PORT_NUM; i++) begin
			req_valid[i] = req_i[i].valid;
			if (sel_comb[i]) begin
				info_d.write  = req_i[i].write;
				info_d.burst  = req_i[i].burst;
				info_d.cached = req_i[i].cached;
				info_d.addr   = req_i[i].addr;
			end
		end
	end

	assign grant = sel_comb & {CACHE_PORT_NUM{take}};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sel_q <= '0;
		end else if (take && |sel_comb) begin
			sel_q <= sel_comb;
		end
	end

	always_ff @(posedge clk) begin
		if (take && |sel_comb) begin
			info_q <= info_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: if (|sel_comb) state_d = ST_ADDR;
			ST_ADDR: begin
				if (info_q.write ? axi_resp_i.aw_ready : axi_resp_i.ar_ready) begin
					state_d = ST_DATA;
				end
			end
			ST_DATA: begin
				if (rd_last) begin
					state_d = ST_IDLE;
				end else if (axi_req_o.w_valid && axi_resp_i.w_ready && beat_last_q) begin
					state_d = ST_RESP;
				end
			end
			ST_RESP: if (axi_resp_i.b_valid) state_d = ST_IDLE; // b_ready is high here
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// write side of the granted port
	always_comb begin
		sel_port = '0;
		for (int i = 0; i < CACHE_PORT_NUM; i++) begin
			if (sel_q[i]) sel_port = req_i[i];
		end
	end

	assign can_load  = !beat_valid_q || axi_resp_i.w_ready;
	assign load_beat = in_data && info_q.write && !wr_done_q && sel_port.data_ok;
	assign wr_ack    = load_beat && can_load;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat_valid_q <= 1'b0;
			wr_done_q    <= 1'b0;
		end else begin
			if (can_load) beat_valid_q <= load_beat;
			if (in_idle) begin
				wr_done_q <= 1'b0;
			end else if (wr_ack && sel_port.data_last) begin
				wr_done_q <= 1'b1;   // stop taking beats
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ack) begin
			beat_data_q <= sel_port.w_data;
			beat_strb_q <= sel_port.data_strobe;
			beat_last_q <= sel_port.data_last;
		end
	end

	assign rd_beat = axi_req_o.r_ready && axi_resp_i.r_valid;
	assign rd_last = rd_beat && axi_resp_i.r_last;

	for (genvar i = 0; i < CACHE_PORT_NUM; i++) begin : g_resp
		assign resp_o[i].ready     = grant[i];
		assign resp_o[i].data_ok   = sel_q[i] && (wr_ack || rd_beat);
		assign resp_o[i].data_last = sel_q[i] && rd_last;
		assign resp_o[i].r_data    = sel_q[i] ? axi_resp_i.r_data : '0;
	end

	always_comb begin
		ax.addr       = info_q.addr;
		ax.len        = info_q.burst ? 8'(`MS_BURST_BEATS - 1) : 8'd0;
		ax.burst_type = 2'b10;   // wrap
		ax.cache      = {2'b00, info_q.cached, 1'b0};

		axi_req_o          = '0;
		axi_req_o.aw       = ax;
		axi_req_o.aw_valid = in_addr && info_q.write;
		axi_req_o.ar       = ax;
		axi_req_o.ar_valid = in_addr && !info_q.write;
		axi_req_o.w_data   = beat_data_q;
		axi_req_o.w_strb   = beat_strb_q;
		axi_req_o.w_last   = beat_last_q;
		axi_req_o.w_valid  = beat_valid_q;
		axi_req_o.r_ready  = in_data && !info_q.write;
		axi_req_o.b_ready  = in_resp;
	end

	a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state_q));

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant));

	// beats are only loaded in data and the last one leaves with the state
	a_w_in_data: assert property (
		@(posedge clk) disable iff (!rst_n)
		axi_req_o.w_valid |-> in_data
	);

endmodule

//--- logic/mem_subsystem.sv
`timescale 1ns/100ps

module mem_subsystem #(
	parameter int CACHE_PORT_NUM = 2
) (
	input  logic                                                clk,
	input  logic                                                rst_n,
	input  mem_subsystem_pkg::cache_bus_req_t  [CACHE_PORT_NUM-1:0] req_i,
	output mem_subsystem_pkg::cache_bus_resp_t [CACHE_PORT_NUM-1:0] resp_o
);

	mem_subsystem_pkg::axi_req_t  axi_req;   // converter to sram
	mem_subsystem_pkg::axi_resp_t axi_resp;  // sram to converter

	// arbitration and protocol conversion
	cache_axi_converter #(
		.CACHE_PORT_NUM (CACHE_PORT_NUM)
	) u_cache_axi_converter (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_i      (req_i),
		.resp_o     (resp_o),
		.axi_req_o  (axi_req),
		.axi_resp_i (axi_resp)
	);

	axi_sram_slave u_axi_sram_slave (
		.clk        (clk),
		.rst_n      (rst_n),
		.axi_req_i  (axi_req),
		.axi_resp_o (axi_resp)
	);

endmodule

//--- logic/mem_subsystem_consts.svh
`ifndef MEM_SUBSYSTEM_CONSTS_SVH
`define MEM_SUBSYSTEM_CONSTS_SVH

// bus data width in bits
`define MS_DATA_W 32

// byte address width
`define MS_ADDR_W 32

// beats per burst, axi len is one less
// 4 beats of 32 bits make a 16 byte wrap block
`define MS_BURST_BEATS 4

// sram depth in words
`define MS_SRAM_WORDS 256

`endif

//--- logic/mem_subsystem_pkg.sv
`include "mem_subsystem_consts.svh"

package mem_subsystem_pkg;

	// request from one cache port
	typedef struct packed {
		logic                        valid;
		logic                        write;
		logic                        burst;       // four beat wrap when set
		logic                        cached;
		logic [`MS_ADDR_W-1:0]       addr;
		logic                        data_ok;     // write beat offered
		logic                        data_last;   // final write beat
		logic [`MS_DATA_W/8-1:0]     data_strobe;
		logic [`MS_DATA_W-1:0]       w_data;
	} cache_bus_req_t;

	// answer back to one cache port
	typedef struct packed {
		logic                  ready;     // one cycle grant
		logic                  data_ok;   // write beat taken or read beat valid
		logic                  data_last; // last read beat
		logic [`MS_DATA_W-1:0] r_data;
	} cache_bus_resp_t;

	// address channel, used for both ar and aw
	typedef struct packed {
		logic [`MS_ADDR_W-1:0] addr;
		logic [7:0]            len;
		logic [1:0]            burst_type; // 2'b10 is wrap
		logic [3:0]            cache;
	} axi_ax_t;

	// master to slave
	typedef struct packed {
		axi_ax_t                 aw;
		logic                    aw_valid;
		axi_ax_t                 ar;
		logic                    ar_valid;
		logic [`MS_DATA_W-1:0]   w_data;
		logic [`MS_DATA_W/8-1:0] w_strb;
		logic                    w_last;
		logic                    w_valid;
		logic                    r_ready;
		logic                    b_ready;
	} axi_req_t;

	// slave to master
	// no ids and no error codes on r and b
	typedef struct packed {
		logic                  aw_ready;
		logic                  ar_ready;
		logic                  w_ready;
		logic [`MS_DATA_W-1:0] r_data;
		logic                  r_last;
		logic                  r_valid;
		logic                  b_valid;
	} axi_resp_t;

endpackage

//--- logic/rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter #(
	parameter int REQ_NUM = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [REQ_NUM-1:0] req_i,
	input  logic               take_sel_i,
	output logic [REQ_NUM-1:0] sel_o
);

	localparam int PTR_W = (REQ_NUM > 1) ? $clog2(REQ_NUM) : 1;

	logic [PTR_W-1:0] ptr_q;   // highest priority port
	logic [PTR_W-1:0] win_idx;
	logic             found;
	int               idx;

	// first request at or after the pointer
	always_comb begin
		sel_o   = '0;
		win_idx = ptr_q;
		found   = 1'b0;
		idx     = 0;
		for (int k = 0; k < REQ_NUM; k++) begin
			idx = (int'(ptr_q) + k) % REQ_NUM;
			if (!found && req_i[idx]) begin
				sel_o[idx] = 1'b1;
				win_idx    = PTR_W'(idx);
				found      = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr_q <= '0;
		end else if (take_sel_i && found) begin
			// move just past the winner
			ptr_q <= (win_idx == PTR_W'(REQ_NUM - 1)) ? '0 : win_idx + 1'b1;
		end
	end

	a_sel_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(sel_o) && ((sel_o & ~req_i) == '0)
	);

endmodule

//--- mem_subsystem.f
+incdir+logic
logic/mem_subsystem_pkg.sv
logic/rr_arbiter.sv
logic/cache_axi_converter.sv
logic/axi_sram_slave.sv
logic/mem_subsystem.sv
verif/tb_mem_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_mem_subsystem \
	-f mem_subsystem.f \
	--Mdir obj_dir -o tb_mem_subsystem
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/tb_mem_subsystem)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- verif/tb_mem_subsystem.sv
`timescale 1ns/100ps
`include "mem_subsystem_consts.svh"

module tb_mem_subsystem;

	localparam int PORT_NUM   = 2;
	localparam int TXN_NUM    = 12;   // transactions over all tests
	localparam int MAX_CYCLES = 40 * TXN_NUM;
	localparam int STRB_W     = `MS_DATA_W / 8;
	localparam int IDX_W      = $clog2(`MS_SRAM_WORDS);

	typedef logic [`MS_DATA_W-1:0] beat_arr_t [`MS_BURST_BEATS];

	logic clk = 1'b0;
	logic rst_n;
	mem_subsystem_pkg::cache_bus_req_t  [PORT_NUM-1:0] req;
	mem_subsystem_pkg::cache_bus_resp_t [PORT_NUM-1:0] resp;

	logic [`MS_DATA_W-1:0] ref_mem [`MS_SRAM_WORDS];   // expected sram contents
	int value_errs = 0;
	int flow_errs  = 0;
	int cycles     = 0;
	int exp_ptr    = 0;   // round robin pointer model
	int grant_log [$];

	always #20 clk = ~clk;

	mem_subsystem #(
		.CACHE_PORT_NUM (PORT_NUM)
	) u_mem_subsystem (
		.clk    (clk),
		.rst_n  (rst_n),
		.req_i  (req),
		.resp_o (resp)
	);

	task automatic close_run(input bit timed_out);
		$display("errors: value %0d, flow %0d", value_errs, flow_errs);
		if (!timed_out && value_errs == 0 && flow_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout, tests still running after %0d cycles", MAX_CYCLES);
			flow_errs++;
			close_run(1'b1);
		end
	end

	// wrapping beat address inside the aligned 16 byte block
	function automatic logic [`MS_ADDR_W-1:0] beat_addr(input logic [`MS_ADDR_W-1:0] start,
			input int k);
		logic [`MS_ADDR_W-1:0] a;
		a      = start;
		a[3:2] = start[3:2] + 2'(k);
		a[1:0] = 2'b00;
		return a;
	endfunction

	task automatic ref_write(input logic [`MS_ADDR_W-1:0] a, input logic [`MS_DATA_W-1:0] d,
			input logic [STRB_W-1:0] strb);
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b]) ref_mem[a[2 +: IDX_W]][8*b +: 8] = d[8*b +: 8];
		end
	endtask

	task automatic check_rdata(input mem_subsystem_pkg::cache_bus_resp_t rsp,
			input logic [`MS_DATA_W-1:0] exp, input int p);
		if (rsp.r_data !== exp) begin
			value_errs++;
			$display("FAILED r_data exp %h got %h on port %0d", exp, rsp.r_data, p);
		end
	endtask

	task automatic check_last(input mem_subsystem_pkg::cache_bus_resp_t rsp, input logic exp,
			input int p);
		if (rsp.data_last !== exp) begin
			value_errs++;
			$display("FAILED data_last exp %h got %h on port %0d", exp, rsp.data_last, p);
		end
	endtask

	task automatic check_flags_low(input mem_subsystem_pkg::cache_bus_resp_t rsp, input int p);
		logic [2:0] got;
		got = {rsp.ready, rsp.data_ok, rsp.data_last};
		if (got !== 3'b000) begin
			value_errs++;
			$display("FAILED ready/data_ok/data_last exp %h got %h on port %0d", 3'b000, got, p);
		end
	endtask

	// ports outside the running transaction must stay silent
	task automatic check_others(input int p);
		for (int q = 0; q < PORT_NUM; q++) begin
			if (q != p && resp[q].data_ok !== 1'b0) begin
				value_errs++;
				$display("FAILED data_ok exp %h got %h on idle port %0d", 1'b0, resp[q].data_ok, q);
			end
		end
	endtask

	task automatic wait_grant(input int p);
		#10;
		while (resp[p].ready !== 1'b1) begin
			@(negedge clk);
			#10;
		end
		grant_log.push_back(p);
		exp_ptr = (p + 1) % PORT_NUM;
	endtask

	task automatic write_txn(input int p, input logic [`MS_ADDR_W-1:0] addr, input logic burst,
			input beat_arr_t data, input logic [STRB_W-1:0] strb);
		int beats;
		int k;
		beats = burst ? `MS_BURST_BEATS : 1;
		k     = 0;
		@(negedge clk);
		req[p]             = '0;
		req[p].valid       = 1'b1;
		req[p].write       = 1'b1;
		req[p].burst       = burst;
		req[p].cached      = 1'b1;
		req[p].addr        = addr;
		req[p].data_ok     = 1'b1;   // first beat offered with the request
		req[p].data_strobe = strb;
		req[p].w_data      = data[0];
		req[p].data_last   = (beats == 1);
		wait_grant(p);
		while (k < beats) begin
			@(negedge clk);
			req[p].valid     = 1'b0;
			req[p].w_data    = data[k];
			req[p].data_last = (k == beats - 1);
			#10;
			check_others(p);
			if (resp[p].data_ok) begin
				ref_write(beat_addr(addr, k), data[k], strb);
				k++;
			end
		end
		@(negedge clk);
		req[p].data_ok   = 1'b0;
		req[p].data_last = 1'b0;
	endtask

	task automatic read_txn(input int p, input logic [`MS_ADDR_W-1:0] addr, input logic burst);
		int beats;
		int k;
		logic [`MS_ADDR_W-1:0] a;
		beats = burst ? `MS_BURST_BEATS : 1;
		k     = 0;
		@(negedge clk);
		req[p]        = '0;
		req[p].valid  = 1'b1;
		req[p].burst  = burst;
		req[p].cached = 1'b1;
		req[p].addr   = addr;
		wait_grant(p);
		while (k < beats) begin
			@(negedge clk);
			req[p].valid = 1'b0;
			#10;
			check_others(p);
			if (resp[p].data_ok) begin
				check_last(resp[p], k == beats - 1, p);
				a = beat_addr(addr, k);
				check_rdata(resp[p], ref_mem[a[2 +: IDX_W]], p);
				k++;
			end else begin
				check_last(resp[p], 1'b0, p);
			end
		end
	endtask

	task automatic check_order(input int first);
		if (grant_log.size() != 2) begin
			flow_errs++;
			$display("expected two grants in the round but saw %0d", grant_log.size());
		end else if (grant_log[0] != first || grant_log[1] == first) begin
			flow_errs++;
			$display("grant order wrong, expected port %0d first but saw %0d then %0d",
				first, grant_log[0], grant_log[1]);
		end
	endtask

	task automatic reset_outputs_low();
		repeat (4) begin
			@(negedge clk);
			#10;
			for (int p = 0; p < PORT_NUM; p++) check_flags_low(resp[p], p);
		end
		@(negedge clk);
		rst_n = 1'b1;
		repeat (3) begin
			#10;
			for (int p = 0; p < PORT_NUM; p++) check_flags_low(resp[p], p);
			@(negedge clk);
		end
	endtask

	task automatic single_write_merge();
		beat_arr_t d;
		d    = '{default: '0};
		d[0] = $urandom();
		write_txn(0, 32'h40, 1'b0, d, 4'hf);
		d[0] = $urandom();
		write_txn(0, 32'h40, 1'b0, d, 4'b0101);   // lanes 1 and 3 keep old bytes
		read_txn(0, 32'h40, 1'b0);
	endtask

	task automatic burst_wrap_read();
		beat_arr_t d;
		for (int i = 0; i < `MS_BURST_BEATS; i++) d[i] = $urandom();
		write_txn(0, 32'h100, 1'b1, d, 4'hf);
		read_txn(0, 32'h108, 1'b1);   // word 2 first
	endtask

	task automatic cross_port_access();
		beat_arr_t d;
		d    = '{default: '0};
		d[0] = $urandom();
		write_txn(1, 32'h200, 1'b0, d, 4'hf);
		read_txn(0, 32'h200, 1'b0);
	endtask

	task automatic port_contention();
		beat_arr_t d0;
		beat_arr_t d1;
		int first;
		d0    = '{default: '0};
		d1    = '{default: '0};
		d0[0] = $urandom();
		d1[0] = $urandom();
		first = exp_ptr;   // both requesting, so the pointer port wins
		grant_log.delete();
		fork
			write_txn(0, 32'h300, 1'b0, d0, 4'hf);
			write_txn(1, 32'h304, 1'b0, d1, 4'hf);
		join
		check_order(first);
		read_txn(1, 32'h300, 1'b0);   // pointer comes back to port 0
		first = exp_ptr;
		grant_log.delete();
		fork
			read_txn(0, 32'h304, 1'b0);
			read_txn(1, 32'h40, 1'b0);
		join
		check_order(first);
	endtask

	initial begin
		void'($urandom(91));
		rst_n = 1'b0;
		req   = '0;
		reset_outputs_low();
		single_write_merge();
		burst_wrap_read();
		cross_port_access();
		port_contention();
		close_run(1'b0);
	end

endmodule
